//--- eeprom.f
eeprom_pkg.sv
eeprom_fifo.sv
eeprom_wb_slave.sv
eeprom_serial_ctrl.sv
eeprom_top.sv
eeprom_tb_model.sv
eeprom_tb.sv

//--- eeprom_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = eeprom_pkg::FIFO_DEPTH
) (
    input  wire      CLK,
    input  wire      RESET,
    input  wire      push,
    input  payload_t push_data,
    input  wire      pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;

    payload_t                  mem [DEPTH];
    ptr_t                      wr_ptr;
    ptr_t                      rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                      do_push;
    logic                      do_pop;

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop); // room freed by a same-cycle pop

    assign full     = (count == DEPTH);
    assign empty    = (count == 0);
    assign pop_data = mem[rd_ptr];  // show-ahead head

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // eeprom geometry, 2K x 8
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // scl timing in CLK cycles
    localparam int SCL_HALF = 4;
    localparam int SCL_TICK_W = $clog2(2 * SCL_HALF);

    localparam int FIFO_DEPTH = 4;

    // command word: read flag, address, write data
    localparam int CMD_W = 1 + ADDR_W + DATA_W;

    // wishbone word addresses
    localparam logic [1:0] REG_CMD = 2'd0;
    localparam logic [1:0] REG_RDATA = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;

    // status bit positions
    localparam int ST_BUSY = 0;
    localparam int ST_NACK = 1;
    localparam int ST_CMD_FULL = 2;
    localparam int ST_RD_EMPTY = 3;

endpackage

`default_nettype wire

//--- eeprom_serial_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_serial_ctrl (
    input  wire                              CLK,
    input  wire                              RESET,
    input  wire  [eeprom_pkg::CMD_W-1:0]     cmd_data,
    input  wire                              cmd_empty,
    input  wire                              rd_full,
    input  wire                              sda_in,
    output logic                             cmd_pop,
    output logic                             rd_push,
    output logic [eeprom_pkg::DATA_W-1:0]    rd_data,
    output logic                             busy,
    output logic                             nack_event,
    output logic                             scl,
    output logic                             sda_low
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_MNACK,
        S_STOP
    } state_t;

    typedef logic [eeprom_pkg::SCL_TICK_W-1:0] tick_t;

    state_t                           state;
    tick_t                            tick;
    logic [3:0]                       bit_cnt;
    logic [eeprom_pkg::DATA_W-1:0]    shreg;
    logic                             sda_smp;
    logic                             cmd_rd;
    logic [eeprom_pkg::ADDR_W-1:0]    cmd_addr;
    logic [eeprom_pkg::DATA_W-1:0]    cmd_wdata;
    logic                             mid_low;
    logic                             rise;
    logic                             sample;
    logic                             mid_high;
    logic                             last;

    // positions inside one scl period, low half first
    assign mid_low  = (tick == tick_t'(eeprom_pkg::SCL_HALF / 2));
    assign rise     = (tick == tick_t'(eeprom_pkg::SCL_HALF - 1));
    assign sample   = (tick == tick_t'(eeprom_pkg::SCL_HALF));
    assign mid_high = (tick == tick_t'(eeprom_pkg::SCL_HALF + eeprom_pkg::SCL_HALF / 2));
    assign last     = (tick == tick_t'(2 * eeprom_pkg::SCL_HALF - 1));

    // a read needs a free slot for its byte
    assign cmd_pop = (state == S_IDLE) && !cmd_empty &&
                     (!cmd_data[eeprom_pkg::CMD_W-1] || !rd_full);
    assign busy    = (state != S_IDLE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= S_IDLE;
            tick       <= '0;
            bit_cnt    <= '0;
            scl        <= 1'b1;
            sda_low    <= 1'b0;
            rd_push    <= 1'b0;
            nack_event <= 1'b0;
        end
        else
        begin
            rd_push    <= 1'b0;
            nack_event <= 1'b0;
            if (state == S_IDLE)
            begin
                tick <= '0;
                if (cmd_pop)
                begin
                    {cmd_rd, cmd_addr, cmd_wdata} <= cmd_data;
                    scl   <= 1'b0;
                    state <= S_START;
                end
            end
            else
            begin
                tick <= last ? '0 : tick + 1'b1;
                if (rise)
                    scl <= 1'b1;
                if (sample)
                    sda_smp <= sda_in;
                if (last && state != S_STOP)
                    scl <= 1'b0;  // bus stays high after stop
                case (state)
                    S_START, S_RSTART:
                    begin
                        if (mid_low)
                            sda_low <= 1'b0;
                        if (mid_high)
                            sda_low <= 1'b1;  // sda falls with scl high
                        if (last)
                        begin
                            shreg   <= {eeprom_pkg::DEV_CODE, cmd_addr[eeprom_pkg::ADDR_W-1:8],
                                        state == S_RSTART};
                            bit_cnt <= '0;
                            state   <= (state == S_START) ? S_CTRL_W : S_CTRL_R;
                        end
                    end
                    S_CTRL_W, S_ADDR, S_DATA, S_CTRL_R:
                    begin
                        if (mid_low)
                            sda_low <= (bit_cnt != 4'd8) && !shreg[7]; // release for ack
                        if (last)
                        begin
                            if (bit_cnt != 4'd8)
                            begin
                                shreg   <= shreg << 1;
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                            else if (sda_smp)
                            begin
                                // no ack, abort and free a waiting reader
                                nack_event <= 1'b1;
                                state      <= S_STOP;
                                if (cmd_rd)
                                begin
                                    rd_push <= 1'b1;
                                    rd_data <= '1;
                                end
                            end
                            else
                            begin
                                bit_cnt <= '0;
                                case (state)
                                    S_CTRL_W:
                                    begin
                                        shreg <= cmd_addr[7:0];
                                        state <= S_ADDR;
                                    end
                                    S_ADDR:
                                    begin
                                        shreg <= cmd_wdata;
                                        state <= cmd_rd ? S_RSTART : S_DATA;
                                    end
                                    S_DATA:
                                        state <= S_STOP;
                                    default:
                                        state <= S_READ;
                                endcase
                            end
                        end
                    end
                    S_READ:
                    begin
                        if (mid_low)
                            sda_low <= 1'b0;
                        if (last)
                        begin
                            shreg   <= {shreg[eeprom_pkg::DATA_W-2:0], sda_smp};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd7)
                                state <= S_MNACK;
                        end
                    end
                    S_MNACK:
                    begin
                        if (mid_low)
                            sda_low <= 1'b0;  // master nack ends the read
                        if (last)
                        begin
                            rd_push <= 1'b1;
                            rd_data <= shreg;
                            state   <= S_STOP;
                        end
                    end
                    S_STOP:
                    begin
                        if (mid_low)
                            sda_low <= 1'b1;
                        if (mid_high)
                            sda_low <= 1'b0;  // sda rises with scl high
                        if (last)
                            state <= S_IDLE;
                    end
                    default:
                        state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- eeprom_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_tb;

    logic        CLK;
    logic        RESET;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    wire  [31:0] wb_dat_r;
    wire         wb_ack;
    wire         scl;
    wire         sda_low;
    wire         sda;
    wire         model_low;
    wire  [7:0]  last_ctrl;
    logic        no_ack;

    integer      errors;
    integer      checks;
    integer      seed;
    integer      last_wait;
    integer      max_wait;
    integer      k;
    logic [31:0] rdata;
    logic [31:0] rnd;
    logic [7:0]  sb [0:2047];
    logic [10:0] addrs [0:7];

    assign sda = !(sda_low || model_low);  // wired-AND of both pull-downs

    eeprom_top u_eeprom_top (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .scl      (scl),
        .sda_low  (sda_low),
        .sda_in   (sda)
    );

    eeprom_tb_model u_model (
        .scl       (scl),
        .sda       (sda),
        .no_ack    (no_ack),
        .sda_drive (model_low),
        .last_ctrl (last_ctrl)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #50 CLK = !CLK;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        assert (got === exp)
        else
        begin
            errors = errors + 1;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("checks %0d errors %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd);
        integer n;
        n = 0;
        @(posedge CLK);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        @(negedge CLK);
        while (wb_ack !== 1'b1)
        begin
            n = n + 1;
            if (n > 5000)
                abort_on_timeout("wishbone ack");
            @(negedge CLK);
        end
        rd        = wb_dat_r;
        last_wait = n;
        @(posedge CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    function automatic logic [31:0] cmd_word(input logic rd, input logic [10:0] a,
                                             input logic [7:0] d);
        cmd_word = {12'h000, rd, a, d};
    endfunction

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d);
        logic [31:0] dummy;
        bus_cycle(1'b1, eeprom_pkg::REG_CMD, cmd_word(1'b0, a, d), dummy);
        sb[a] = d;
    endtask

    task automatic queue_read(input logic [10:0] a);
        logic [31:0] dummy;
        bus_cycle(1'b1, eeprom_pkg::REG_CMD, cmd_word(1'b1, a, 8'h00), dummy);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        integer n;
        n = 0;
        bus_cycle(1'b0, eeprom_pkg::REG_STATUS, 32'h0, st);
        while (st[eeprom_pkg::ST_BUSY] || !u_eeprom_top.cmd_empty)
        begin
            n = n + 1;
            if (n > 3000)
                abort_on_timeout("engine idle");
            bus_cycle(1'b0, eeprom_pkg::REG_STATUS, 32'h0, st);
        end
    endtask

    initial
    begin
        RESET    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 32'h0;
        no_ack   = 1'b0;
        errors   = 0;
        checks   = 0;
        seed     = 32'hd84a_6673;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;

        // reset values
        @(negedge CLK);
        check_val("wb_ack", wb_ack, 0);
        check_val("scl", scl, 1);
        check_val("sda_low", sda_low, 0);
        bus_cycle(1'b0, eeprom_pkg::REG_STATUS, 32'h0, rdata);
        check_val("status", rdata, 32'h8);

        // single write then read back
        write_byte(11'h5a3, 8'h3c);
        wait_idle();
        check_val("model mem", u_model.mem[11'h5a3], 8'h3c);
        check_val("ctrl code", last_ctrl[7:4], 4'b1010);
        check_val("ctrl block", last_ctrl[3:1], 3'h5);
        queue_read(11'h5a3);
        bus_cycle(1'b0, eeprom_pkg::REG_RDATA, 32'h0, rdata);
        check_val("rdata", rdata, 32'h3c);

        // six back to back writes overflow the command fifo
        max_wait = 0;
        for (k = 0; k < 6; k = k + 1)
        begin
            write_byte(11'h100 + 11'(k * 37), 8'hc0 + 8'(k));
            if (last_wait > max_wait)
                max_wait = last_wait;
        end
        check_val("cmd backpressure", max_wait > 20, 1);
        wait_idle();
        for (k = 0; k < 6; k = k + 1)
            queue_read(11'h100 + 11'(k * 37));
        for (k = 0; k < 6; k = k + 1)
        begin
            bus_cycle(1'b0, eeprom_pkg::REG_RDATA, 32'h0, rdata);
            check_val("rdata", rdata, 32'hc0 + k);
        end

        // one random address in each block
        for (k = 0; k < 8; k = k + 1)
        begin
            rnd      = $random(seed);
            addrs[k] = {k[2:0], rnd[7:0]};
            write_byte(addrs[k], rnd[15:8]);
        end
        wait_idle();
        for (k = 0; k < 8; k = k + 1)
        begin
            queue_read(addrs[k]);
            bus_cycle(1'b0, eeprom_pkg::REG_RDATA, 32'h0, rdata);
            check_val("rdata", rdata, {24'h0, sb[addrs[k]]});
        end

        // missing acknowledge
        no_ack <= 1'b1;
        queue_read(11'h222);
        bus_cycle(1'b0, eeprom_pkg::REG_RDATA, 32'h0, rdata);
        check_val("rdata", rdata, 32'hff);
        wait_idle();
        bus_cycle(1'b0, eeprom_pkg::REG_STATUS, 32'h0, rdata);
        check_val("status nack", rdata[eeprom_pkg::ST_NACK], 1);
        bus_cycle(1'b1, eeprom_pkg::REG_STATUS, 32'h2, rdata);
        bus_cycle(1'b0, eeprom_pkg::REG_STATUS, 32'h0, rdata);
        check_val("status nack", rdata[eeprom_pkg::ST_NACK], 0);
        no_ack <= 1'b0;
        write_byte(11'h222, 8'h99);
        queue_read(11'h222);
        bus_cycle(1'b0, eeprom_pkg::REG_RDATA, 32'h0, rdata);
        check_val("rdata", rdata, 32'h99);
        wait_idle();

        // unmapped register
        bus_cycle(1'b0, 2'd3, 32'h0, rdata);
        check_val("unmapped rdata", rdata, 32'h0);
        bus_cycle(1'b1, 2'd3, 32'hffff_ffff, rdata);
        bus_cycle(1'b0, eeprom_pkg::REG_STATUS, 32'h0, rdata);
        check_val("status", rdata, 32'h8);  // idle, read fifo empty
        check_val("model frame errors", u_model.frame_errs, 0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- eeprom_tb_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_tb_model (
    input  wire        scl,
    input  wire        sda,
    input  wire        no_ack,
    output logic       sda_drive,
    output logic [7:0] last_ctrl
);

    localparam int M_IDLE  = 0;
    localparam int M_CTRL  = 1;
    localparam int M_ADDR  = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    logic [7:0]  mem [0:2047];
    integer      frame_errs;
    integer      state;
    integer      bitc;
    integer      i;
    logic        ack_phase;
    logic        rw;
    logic        prev_scl;
    logic        prev_sda;
    logic [7:0]  shreg;
    logic [7:0]  out;
    logic [10:0] addr;

    initial
    begin
        sda_drive  = 1'b0;
        last_ctrl  = 8'h00;
        frame_errs = 0;
        state      = M_IDLE;
        bitc       = 0;
        ack_phase  = 1'b0;
        rw         = 1'b0;
        addr       = '0;
        for (i = 0; i < 2048; i = i + 1)
            mem[i] = i[7:0] ^ {i[10:8], 5'h15}; // whole address in the fill
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && prev_scl === 1'b1 && prev_sda === 1'b1 && sda === 1'b0)
        begin
            state     = M_CTRL;  // start or repeated start
            bitc      = 0;
            ack_phase = 1'b0;
            sda_drive = 1'b0;
        end
        else if (scl === 1'b1 && prev_scl === 1'b1 && prev_sda === 1'b0 && sda === 1'b1)
        begin
            state     = M_IDLE;  // stop
            sda_drive = 1'b0;
        end
        else if (prev_scl === 1'b0 && scl === 1'b1)
        begin
            if (state == M_RDATA)
                bitc = bitc + 1;
            else if (state != M_IDLE && !ack_phase && bitc < 8)
            begin
                shreg = {shreg[6:0], sda};
                bitc  = bitc + 1;
            end
        end
        else if (prev_scl === 1'b1 && scl === 1'b0)
        begin
            if (state == M_RDATA)
            begin
                if (bitc < 8)
                    sda_drive = !out[7 - bitc];
                else
                begin
                    sda_drive = 1'b0;  // master nack slot
                    state     = M_IDLE;
                end
            end
            else if (state != M_IDLE && ack_phase)
            begin
                sda_drive = 1'b0;
                ack_phase = 1'b0;
                bitc      = 0;
                case (state)
                    M_CTRL:
                    begin
                        if (rw)
                        begin
                            state     = M_RDATA;
                            out       = mem[addr];
                            sda_drive = !out[7];
                        end
                        else
                            state = M_ADDR;
                    end
                    M_ADDR:
                        state = M_WDATA;
                    default:
                        state = M_IDLE;
                endcase
            end
            else if (state != M_IDLE && bitc == 8)
            begin
                case (state)
                    M_CTRL:
                    begin
                        last_ctrl = shreg;
                        if (shreg[7:4] != 4'b1010)
                            frame_errs = frame_errs + 1;
                        if (shreg[0] && shreg[3:1] != addr[10:8])
                            frame_errs = frame_errs + 1; // block must match the write phase
                        rw         = shreg[0];
                        addr[10:8] = shreg[3:1];
                    end
                    M_ADDR:
                        addr[7:0] = shreg;
                    default:
                        mem[addr] = shreg;
                endcase
                if (no_ack)
                    state = M_IDLE;
                else
                begin
                    sda_drive = 1'b1;
                    ack_phase = 1'b1;
                end
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

`default_nettype wire

//--- eeprom_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_top (
    input  wire         CLK,
    input  wire         RESET,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [1:0]  wb_adr,
    input  wire  [31:0] wb_dat_w,
    output wire  [31:0] wb_dat_r,
    output wire         wb_ack,
    output wire         scl,
    output wire         sda_low,
    input  wire         sda_in
);

    wire                            cmd_push;
    wire [eeprom_pkg::CMD_W-1:0]    cmd_wdata;
    wire                            cmd_full;
    wire                            cmd_pop;
    wire [eeprom_pkg::CMD_W-1:0]    cmd_head;
    wire                            cmd_empty;
    wire                            rd_push;
    wire [eeprom_pkg::DATA_W-1:0]   rd_wdata;
    wire                            rd_full;
    wire                            rd_pop;
    wire [eeprom_pkg::DATA_W-1:0]   rd_head;
    wire                            rd_empty;
    wire                            busy;
    wire                            nack_event;

    eeprom_wb_slave u_wb_slave (
        .CLK        (CLK),
        .RESET      (RESET),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .cmd_push   (cmd_push),
        .cmd_data   (cmd_wdata),
        .cmd_full   (cmd_full),
        .rd_pop     (rd_pop),
        .rd_data    (rd_head),
        .rd_empty   (rd_empty),
        .busy       (busy),
        .nack_event (nack_event)
    );

    // host to engine
    eeprom_fifo #(
        .payload_t (logic [eeprom_pkg::CMD_W-1:0]),
        .DEPTH     (eeprom_pkg::FIFO_DEPTH)
    ) u_cmd_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (cmd_push),
        .push_data (cmd_wdata),
        .pop       (cmd_pop),
        .pop_data  (cmd_head),
        .full      (cmd_full),
        .empty     (cmd_empty)
    );

    // engine back to host
    eeprom_fifo #(
        .payload_t (logic [eeprom_pkg::DATA_W-1:0]),
        .DEPTH     (eeprom_pkg::FIFO_DEPTH)
    ) u_rd_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (rd_push),
        .push_data (rd_wdata),
        .pop       (rd_pop),
        .pop_data  (rd_head),
        .full      (rd_full),
        .empty     (rd_empty)
    );

    eeprom_serial_ctrl u_serial_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_data   (cmd_head),
        .cmd_empty  (cmd_empty),
        .rd_full    (rd_full),
        .sda_in     (sda_in),
        .cmd_pop    (cmd_pop),
        .rd_push    (rd_push),
        .rd_data    (rd_wdata),
        .busy       (busy),
        .nack_event (nack_event),
        .scl        (scl),
        .sda_low    (sda_low)
    );

endmodule

`default_nettype wire

//--- eeprom_wb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_wb_slave (
    input  wire                              CLK,
    input  wire                              RESET,
    input  wire                              wb_cyc,
    input  wire                              wb_stb,
    input  wire                              wb_we,
    input  wire  [1:0]                       wb_adr,
    input  wire  [31:0]                      wb_dat_w,
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack,
    output logic                             cmd_push,
    output logic [eeprom_pkg::CMD_W-1:0]     cmd_data,
    input  wire                              cmd_full,
    output logic                             rd_pop,
    input  wire  [eeprom_pkg::DATA_W-1:0]    rd_data,
    input  wire                              rd_empty,
    input  wire                              busy,
    input  wire                              nack_event
);

    logic cmd_wr;
    logic rdata_rd;
    logic status_wr;
    logic ready;
    logic nack;

    assign cmd_wr    = wb_we && (wb_adr == eeprom_pkg::REG_CMD);
    assign rdata_rd  = !wb_we && (wb_adr == eeprom_pkg::REG_RDATA);
    assign status_wr = wb_we && (wb_adr == eeprom_pkg::REG_STATUS);

    // back-pressure only on the two fifo registers
    always_comb
    begin
        ready = 1'b1;
        if (cmd_wr)
            ready = !cmd_full;
        else if (rdata_rd)
            ready = !rd_empty;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc && wb_stb && !wb_ack && ready;
    end

    // fifo handshakes land in the ack cycle
    assign cmd_push = wb_ack && cmd_wr;
    assign cmd_data = wb_dat_w[eeprom_pkg::CMD_W-1:0];
    assign rd_pop   = wb_ack && rdata_rd;

    // sticky, set wins over a clear
    always_ff @(posedge CLK)
    begin
        if (RESET)
            nack <= 1'b0;
        else if (nack_event)
            nack <= 1'b1;
        else if (wb_ack && status_wr && wb_dat_w[eeprom_pkg::ST_NACK])
            nack <= 1'b0;
    end

    always_comb
    begin
        wb_dat_r = '0;
        case (wb_adr)
            eeprom_pkg::REG_RDATA:
                wb_dat_r[eeprom_pkg::DATA_W-1:0] = rd_data;
            eeprom_pkg::REG_STATUS:
            begin
                wb_dat_r[eeprom_pkg::ST_BUSY]     = busy;
                wb_dat_r[eeprom_pkg::ST_NACK]     = nack;
                wb_dat_r[eeprom_pkg::ST_CMD_FULL] = cmd_full;
                wb_dat_r[eeprom_pkg::ST_RD_EMPTY] = rd_empty;
            end
            default:
                wb_dat_r = '0;  // cmd reads back as zero
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/bash
# build and run the eeprom controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module eeprom_tb -f eeprom.f -o eeprom_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/eeprom_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
